// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // ============================
    // Major opcodes
    // ============================
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;

    // ============================
    // funct3 codes
    // ============================
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    // Access width for loads and stores
    localparam logic [2:0] f3_w   = 3'b010;
    localparam logic [2:0] f3_d   = 3'b011;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    // Upper six bits of f7_alt also select srai
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    localparam logic [4:0] reg_zero = 5'd0;
    localparam logic [4:0] reg_ra   = 5'd1;
    localparam logic [4:0] reg_sp   = 5'd2;

    localparam logic [31:0] instr_ebreak = 32'h0010_0073;

endpackage

// ==== verilog/rvc_pkg.sv ====
package rvc_pkg;

    // Quadrant codes in bits [1:0]
    localparam logic [1:0] quad_c0   = 2'b00;
    localparam logic [1:0] quad_c1   = 2'b01;
    localparam logic [1:0] quad_c2   = 2'b10;
    localparam logic [1:0] quad_none = 2'b11;

    // 3-bit register fields address x8 to x15
    localparam logic [1:0] prime_base = 2'b01;

    // ============================
    // Compressed formats
    // ============================
    typedef struct packed {
        logic [3:0] funct4;
        logic [4:0] rd_rs1;
        logic [4:0] rs2;
        logic [1:0] op;
    } cr_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic       imm_hi;
        logic [4:0] rd_rs1;
        logic [4:0] imm_lo;
        logic [1:0] op;
    } ci_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [5:0] imm;
        logic [4:0] rs2;
        logic [1:0] op;
    } css_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [7:0] imm;
        logic [2:0] rd_p;
        logic [1:0] op;
    } ciw_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] imm_hi;
        logic [2:0] rs1_p;
        logic [1:0] imm_lo;
        logic [2:0] rd_p;
        logic [1:0] op;
    } cl_t;

    // imm_lo doubles as funct2 of the register arithmetic forms
    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] imm_hi;
        logic [2:0] rs1_p;
        logic [1:0] imm_lo;
        logic [2:0] rs2_p;
        logic [1:0] op;
    } cs_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] off_hi;
        logic [2:0] rs1_p;
        logic [4:0] off_lo;
        logic [1:0] op;
    } cb_t;

    typedef struct packed {
        logic [2:0]  funct3;
        logic [10:0] target;
        logic [1:0]  op;
    } cj_t;

    typedef union packed {
        cr_t  cr;
        ci_t  ci;
        css_t css;
        ciw_t ciw;
        cl_t  cl;
        cs_t  cs;
        cb_t  cb;
        cj_t  cj;
    } rvc_word_t;

endpackage

// ==== verilog/rvc_quadrant0.sv ====
`timescale 1ns/10ps

module rvc_quadrant0 #(
    parameter bit rv64 = 1'b1
) (
    input  rvc_pkg::rvc_word_t cinstr,
    output logic [31:0]        instr,
    output logic               legal
);

    logic [4:0]  rd_p;
    logic [4:0]  rs1_p;
    logic [4:0]  rs2_p;
    logic [9:0]  imm_4spn;
    logic [11:0] off_w;
    logic [11:0] off_d;
    logic [31:0] expanded;

    assign rd_p  = {rvc_pkg::prime_base, cinstr.cl.rd_p};
    assign rs1_p = {rvc_pkg::prime_base, cinstr.cl.rs1_p};
    assign rs2_p = {rvc_pkg::prime_base, cinstr.cs.rs2_p};

    // nzuimm[5:4|9:6|2|3] scaled by 4
    assign imm_4spn = {cinstr.ciw.imm[5:2], cinstr.ciw.imm[7:6],
                       cinstr.ciw.imm[0], cinstr.ciw.imm[1], 2'b00};

    // Same offset layout for the CL and CS forms
    assign off_w = {5'b0, cinstr.cl.imm_lo[0], cinstr.cl.imm_hi, cinstr.cl.imm_lo[1], 2'b00};
    assign off_d = {4'b0, cinstr.cl.imm_lo, cinstr.cl.imm_hi, 3'b000};

    always_comb begin
        expanded = '0;
        legal    = 1'b0;
        case (cinstr.cl.funct3)
            3'b000: begin
                // C.ADDI4SPN, zero immediate is reserved
                legal    = (imm_4spn != 10'd0);
                expanded = {2'b00, imm_4spn, rv_isa_pkg::reg_sp, rv_isa_pkg::f3_add,
                            {rvc_pkg::prime_base, cinstr.ciw.rd_p}, rv_isa_pkg::opc_op_imm};
            end
            3'b010: begin
                legal    = 1'b1;
                expanded = {off_w, rs1_p, rv_isa_pkg::f3_w, rd_p, rv_isa_pkg::opc_load};
            end
            3'b011: begin
                // C.LD, floating-point slot in RV32
                legal    = rv64;
                expanded = {off_d, rs1_p, rv_isa_pkg::f3_d, rd_p, rv_isa_pkg::opc_load};
            end
            3'b110: begin
                legal    = 1'b1;
                expanded = {off_w[11:5], rs2_p, rs1_p, rv_isa_pkg::f3_w, off_w[4:0],
                            rv_isa_pkg::opc_store};
            end
            3'b111: begin
                // C.SD
                legal    = rv64;
                expanded = {off_d[11:5], rs2_p, rs1_p, rv_isa_pkg::f3_d, off_d[4:0],
                            rv_isa_pkg::opc_store};
            end
            // FLD, FSD and the reserved slot
            default: legal = 1'b0;
        endcase
    end

    assign instr = legal ? expanded : 32'h0;

endmodule

// ==== verilog/rvc_quadrant1.sv ====
`timescale 1ns/10ps

module rvc_quadrant1 #(
    parameter bit rv64 = 1'b1
) (
    input  rvc_pkg::rvc_word_t cinstr,
    output logic [31:0]        instr,
    output logic               legal
);

    logic [4:0]  rd;
    logic [4:0]  rd_p;
    logic [4:0]  rs2_p;
    logic [5:0]  shamt;
    logic [11:0] imm_ci;
    logic [11:0] imm_16sp;
    logic [19:0] imm_lui;
    logic [20:0] imm_j;
    logic [12:0] imm_b;
    logic [31:0] expanded;

    assign rd    = cinstr.ci.rd_rs1;
    assign rd_p  = {rvc_pkg::prime_base, cinstr.cb.rs1_p};
    assign rs2_p = {rvc_pkg::prime_base, cinstr.cs.rs2_p};
    assign shamt = {cinstr.cb.off_hi[2], cinstr.cb.off_lo};

    // ============================
    // Immediates
    // ============================
    assign imm_ci = {{7{cinstr.ci.imm_hi}}, cinstr.ci.imm_lo};

    // nzimm[9|4|6|8:7|5] scaled by 16
    assign imm_16sp = {{3{cinstr.ci.imm_hi}}, cinstr.ci.imm_lo[2:1], cinstr.ci.imm_lo[3],
                       cinstr.ci.imm_lo[0], cinstr.ci.imm_lo[4], 4'b0000};

    assign imm_lui = {{15{cinstr.ci.imm_hi}}, cinstr.ci.imm_lo};

    // offset[11|4|9:8|10|6|7|3:1|5]
    assign imm_j = {{10{cinstr.cj.target[10]}}, cinstr.cj.target[6], cinstr.cj.target[8:7],
                    cinstr.cj.target[4], cinstr.cj.target[5], cinstr.cj.target[0],
                    cinstr.cj.target[9], cinstr.cj.target[3:1], 1'b0};

    // offset[8|4:3] and offset[7:6|2:1|5]
    assign imm_b = {{5{cinstr.cb.off_hi[2]}}, cinstr.cb.off_lo[4:3], cinstr.cb.off_lo[0],
                    cinstr.cb.off_hi[1:0], cinstr.cb.off_lo[2:1], 1'b0};

    always_comb begin
        expanded = '0;
        legal    = 1'b1;
        case (cinstr.ci.funct3)
            3'b000: begin
                // C.NOP and C.ADDI
                expanded = {imm_ci, rd, rv_isa_pkg::f3_add, rd, rv_isa_pkg::opc_op_imm};
            end
            3'b001: begin
                if (rv64) begin
                    legal    = (rd != rv_isa_pkg::reg_zero);
                    expanded = {imm_ci, rd, rv_isa_pkg::f3_add, rd, rv_isa_pkg::opc_op_imm_32};
                end else begin
                    // C.JAL links to ra
                    expanded = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12],
                                rv_isa_pkg::reg_ra, rv_isa_pkg::opc_jal};
                end
            end
            3'b010: begin
                expanded = {imm_ci, rv_isa_pkg::reg_zero, rv_isa_pkg::f3_add, rd,
                            rv_isa_pkg::opc_op_imm};
            end
            3'b011: begin
                if (rd == rv_isa_pkg::reg_sp) begin
                    legal    = (imm_16sp != 12'd0);
                    expanded = {imm_16sp, rv_isa_pkg::reg_sp, rv_isa_pkg::f3_add,
                                rv_isa_pkg::reg_sp, rv_isa_pkg::opc_op_imm};
                end else begin
                    legal    = (rd != rv_isa_pkg::reg_zero);
                    expanded = {imm_lui, rd, rv_isa_pkg::opc_lui};
                end
            end
            3'b100: begin
                case (cinstr.cb.off_hi[1:0])
                    2'b00: expanded = {rv_isa_pkg::f7_base[6:1], shamt, rd_p, rv_isa_pkg::f3_srl,
                                       rd_p, rv_isa_pkg::opc_op_imm};
                    2'b01: expanded = {rv_isa_pkg::f7_alt[6:1], shamt, rd_p, rv_isa_pkg::f3_srl,
                                       rd_p, rv_isa_pkg::opc_op_imm};
                    2'b10: expanded = {imm_ci, rd_p, rv_isa_pkg::f3_and, rd_p,
                                       rv_isa_pkg::opc_op_imm};
                    default: begin
                        // Register forms, funct2 picks the operation
                        case ({cinstr.cb.off_hi[2], cinstr.cs.imm_lo})
                            3'b000: expanded = {rv_isa_pkg::f7_alt, rs2_p, rd_p,
                                                rv_isa_pkg::f3_add, rd_p, rv_isa_pkg::opc_op};
                            3'b001: expanded = {rv_isa_pkg::f7_base, rs2_p, rd_p,
                                                rv_isa_pkg::f3_xor, rd_p, rv_isa_pkg::opc_op};
                            3'b010: expanded = {rv_isa_pkg::f7_base, rs2_p, rd_p,
                                                rv_isa_pkg::f3_or, rd_p, rv_isa_pkg::opc_op};
                            3'b011: expanded = {rv_isa_pkg::f7_base, rs2_p, rd_p,
                                                rv_isa_pkg::f3_and, rd_p, rv_isa_pkg::opc_op};
                            3'b100: begin
                                legal    = rv64;
                                expanded = {rv_isa_pkg::f7_alt, rs2_p, rd_p,
                                            rv_isa_pkg::f3_add, rd_p, rv_isa_pkg::opc_op_32};
                            end
                            3'b101: begin
                                legal    = rv64;
                                expanded = {rv_isa_pkg::f7_base, rs2_p, rd_p,
                                            rv_isa_pkg::f3_add, rd_p, rv_isa_pkg::opc_op_32};
                            end
                            default: legal = 1'b0;
                        endcase
                    end
                endcase
            end
            3'b101: begin
                expanded = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12],
                            rv_isa_pkg::reg_zero, rv_isa_pkg::opc_jal};
            end
            default: begin
                // C.BEQZ and C.BNEZ differ only in funct3 bit 0
                expanded = {imm_b[12], imm_b[10:5], rv_isa_pkg::reg_zero, rd_p,
                            cinstr.cb.funct3[0] ? rv_isa_pkg::f3_bne : rv_isa_pkg::f3_beq,
                            imm_b[4:1], imm_b[11], rv_isa_pkg::opc_branch};
            end
        endcase
    end

    assign instr = legal ? expanded : 32'h0;

endmodule

// ==== verilog/rvc_quadrant2.sv ====
`timescale 1ns/10ps

module rvc_quadrant2 #(
    parameter bit rv64 = 1'b1
) (
    input  rvc_pkg::rvc_word_t cinstr,
    output logic [31:0]        instr,
    output logic               legal
);

    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] off_lwsp;
    logic [11:0] off_ldsp;
    logic [11:0] off_swsp;
    logic [11:0] off_sdsp;
    logic [31:0] expanded;

    assign rd  = cinstr.cr.rd_rs1;
    assign rs2 = cinstr.cr.rs2;

    // Stack offsets, zero extended
    assign off_lwsp = {4'b0, cinstr.ci.imm_lo[1:0], cinstr.ci.imm_hi, cinstr.ci.imm_lo[4:2],
                       2'b00};
    assign off_ldsp = {3'b0, cinstr.ci.imm_lo[2:0], cinstr.ci.imm_hi, cinstr.ci.imm_lo[4:3],
                       3'b000};
    assign off_swsp = {4'b0, cinstr.css.imm[1:0], cinstr.css.imm[5:2], 2'b00};
    assign off_sdsp = {3'b0, cinstr.css.imm[2:0], cinstr.css.imm[5:3], 3'b000};

    always_comb begin
        expanded = '0;
        legal    = 1'b1;
        case (cinstr.ci.funct3)
            3'b000: begin
                legal    = (rd != rv_isa_pkg::reg_zero);
                expanded = {rv_isa_pkg::f7_base[6:1], cinstr.ci.imm_hi, cinstr.ci.imm_lo, rd,
                            rv_isa_pkg::f3_sll, rd, rv_isa_pkg::opc_op_imm};
            end
            3'b010: begin
                legal    = (rd != rv_isa_pkg::reg_zero);
                expanded = {off_lwsp, rv_isa_pkg::reg_sp, rv_isa_pkg::f3_w, rd,
                            rv_isa_pkg::opc_load};
            end
            3'b011: begin
                legal    = rv64 && (rd != rv_isa_pkg::reg_zero);
                expanded = {off_ldsp, rv_isa_pkg::reg_sp, rv_isa_pkg::f3_d, rd,
                            rv_isa_pkg::opc_load};
            end
            3'b100: begin
                if (rs2 == rv_isa_pkg::reg_zero) begin
                    if (!cinstr.cr.funct4[0]) begin
                        // C.JR
                        legal    = (rd != rv_isa_pkg::reg_zero);
                        expanded = {12'h000, rd, 3'b000, rv_isa_pkg::reg_zero,
                                    rv_isa_pkg::opc_jalr};
                    end else if (rd == rv_isa_pkg::reg_zero) begin
                        expanded = rv_isa_pkg::instr_ebreak;
                    end else begin
                        // C.JALR links to ra
                        expanded = {12'h000, rd, 3'b000, rv_isa_pkg::reg_ra,
                                    rv_isa_pkg::opc_jalr};
                    end
                end else begin
                    // C.MV reads x0, C.ADD reads rd
                    expanded = {rv_isa_pkg::f7_base, rs2,
                                cinstr.cr.funct4[0] ? rd : rv_isa_pkg::reg_zero,
                                rv_isa_pkg::f3_add, rd, rv_isa_pkg::opc_op};
                end
            end
            3'b110: begin
                expanded = {off_swsp[11:5], cinstr.css.rs2, rv_isa_pkg::reg_sp, rv_isa_pkg::f3_w,
                            off_swsp[4:0], rv_isa_pkg::opc_store};
            end
            3'b111: begin
                legal    = rv64;
                expanded = {off_sdsp[11:5], cinstr.css.rs2, rv_isa_pkg::reg_sp, rv_isa_pkg::f3_d,
                            off_sdsp[4:0], rv_isa_pkg::opc_store};
            end
            // FLDSP and FSDSP
            default: legal = 1'b0;
        endcase
    end

    assign instr = legal ? expanded : 32'h0;

endmodule

// ==== verilog/rvc_expander.sv ====
`timescale 1ns/10ps

module rvc_expander #(
    parameter bit rv64 = 1'b1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [15:0] cinstr,
    output logic        out_valid,
    output logic [31:0] instr,
    output logic        legal,
    output logic        is_compressed
);

    rvc_pkg::rvc_word_t word;
    logic [31:0]        q0_instr;
    logic [31:0]        q1_instr;
    logic [31:0]        q2_instr;
    logic               q0_legal;
    logic               q1_legal;
    logic               q2_legal;
    logic [31:0]        sel_instr;
    logic               sel_legal;

    assign word = cinstr;

    // ============================
    // Quadrant decoders
    // ============================
    rvc_quadrant0 #(.rv64(rv64)) u_quad0 (.cinstr(word), .instr(q0_instr), .legal(q0_legal));
    rvc_quadrant1 #(.rv64(rv64)) u_quad1 (.cinstr(word), .instr(q1_instr), .legal(q1_legal));
    rvc_quadrant2 #(.rv64(rv64)) u_quad2 (.cinstr(word), .instr(q2_instr), .legal(q2_legal));

    always_comb begin
        case (word.cr.op)
            rvc_pkg::quad_c0: begin
                sel_instr = q0_instr;
                sel_legal = q0_legal;
            end
            rvc_pkg::quad_c1: begin
                sel_instr = q1_instr;
                sel_legal = q1_legal;
            end
            rvc_pkg::quad_c2: begin
                sel_instr = q2_instr;
                sel_legal = q2_legal;
            end
            // 32-bit word, nothing to expand
            rvc_pkg::quad_none: begin
                sel_instr = 32'h0;
                sel_legal = 1'b0;
            end
        endcase
    end

    // ============================
    // Output register
    // ============================
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid     <= 1'b0;
            instr         <= 32'h0;
            legal         <= 1'b0;
            is_compressed <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                instr         <= sel_instr;
                legal         <= sel_legal;
                is_compressed <= (word.cr.op != rvc_pkg::quad_none);
            end
        end
    end

endmodule

// ==== test/rvc_expander_asserts.sv ====
`timescale 1ns/10ps

module rvc_expander_asserts (
    input logic        clk,
    input logic        reset,
    input logic        in_valid,
    input logic        out_valid,
    input logic [31:0] instr,
    input logic        legal,
    input logic        is_compressed
);

    // ============================
    // Output stage
    // ============================
    a_reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // One cycle of latency, no bubbles added or removed
    a_valid_follows_input: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (out_valid == $past(in_valid)))
        else $error("out_valid does not follow in_valid of the previous cycle");

    a_illegal_is_zero: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !legal) |-> (instr == 32'h0))
        else $error("illegal result carries a nonzero instruction");

    // A 32-bit word is never reported legal
    a_legal_needs_compressed: assert property (@(posedge clk) disable iff (reset)
        legal |-> is_compressed)
        else $error("legal is high while is_compressed is low");

endmodule

bind rvc_expander rvc_expander_asserts u_asserts (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .out_valid     (out_valid),
    .instr         (instr),
    .legal         (legal),
    .is_compressed (is_compressed)
);

// ==== test/tb_rvc_expander.sv ====
`timescale 1ns/10ps

module tb_rvc_expander;

    localparam int wait_limit   = 20;
    localparam int random_words = 200;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic [15:0] cinstr;
    logic        out_valid;
    logic [31:0] instr;
    logic        legal;
    logic        is_compressed;

    // Vectors from the data file
    logic [15:0] vec_word[$];
    logic        vec_legal[$];
    logic [31:0] vec_instr[$];

    logic [31:0] rng_state;

    rvc_expander #(.rv64(1'b1)) u_dut (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .cinstr        (cinstr),
        .out_valid     (out_valid),
        .instr         (instr),
        .legal         (legal),
        .is_compressed (is_compressed)
    );

    always #10 clk = ~clk;

    // ============================
    // Helpers
    // ============================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [15:0] word;
        logic [31:0] exp_legal;
        logic [31:0] exp_instr;
        fd = $fopen("test/rvc_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open the vector file test/rvc_testdata.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines carry no vector
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%h %h %h", word, exp_legal, exp_instr);
                if (fields == 3) begin
                    vec_word.push_back(word);
                    vec_legal.push_back(exp_legal[0]);
                    vec_instr.push_back(exp_instr);
                end
            end
        end
        $fclose(fd);
        if (vec_word.size() == 0) begin
            stop_with_failure("The vector file holds no vectors");
        end
    endtask

    // Drive one word, wait for its result and compare it
    task automatic expand_one(input logic [15:0] word, input logic exp_legal,
                              input logic [31:0] exp_instr, input logic exp_compressed);
        int waited;
        @(posedge clk);
        in_valid <= 1'b1;
        cinstr   <= word;
        @(posedge clk);
        in_valid <= 1'b0;
        cinstr   <= 16'h0;
        waited = 0;
        @(negedge clk);
        while (out_valid !== 1'b1) begin
            waited++;
            if (waited > wait_limit) begin
                stop_with_failure($sformatf("No out_valid within %0d cycles for word 0x%04h",
                                            wait_limit, word));
            end
            @(negedge clk);
        end
        check_value("out_valid delay", waited, 0);
        check_value($sformatf("is_compressed (cinstr 0x%04h)", word), 32'(is_compressed),
                    32'(exp_compressed));
        check_value($sformatf("legal (cinstr 0x%04h)", word), 32'(legal), 32'(exp_legal));
        check_value($sformatf("instr (cinstr 0x%04h)", word), instr, exp_instr);
    endtask

    // Back-to-back words with one idle slot; latency is fixed at one cycle
    task automatic stream_vectors();
        int   slot;
        int   next_idx;
        int   prev_idx;
        logic cur_valid;
        logic prev_valid;
        next_idx   = 0;
        prev_idx   = 0;
        prev_valid = 1'b0;
        for (slot = 0; slot < 8; slot++) begin
            // Slot 2 is the gap and slot 7 drains the stage
            cur_valid = (slot != 2) && (slot != 7);
            @(posedge clk);
            in_valid <= cur_valid;
            cinstr   <= cur_valid ? vec_word[next_idx % vec_word.size()] : 16'h0;
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'(prev_valid));
            if (prev_valid) begin
                check_value("is_compressed", 32'(is_compressed), 32'h1);
                check_value("legal", 32'(legal), 32'(vec_legal[prev_idx]));
                check_value("instr", instr, vec_instr[prev_idx]);
            end
            prev_valid = cur_valid;
            prev_idx   = next_idx % vec_word.size();
            if (cur_valid) begin
                next_idx++;
            end
        end
    endtask

    // ============================
    // Main sequence
    // ============================
    initial begin
        int idx;
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        cinstr      = 16'h0;
        rng_state   = 32'd2;
        load_vectors();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("legal", 32'(legal), 32'h0);
        check_value("is_compressed", 32'(is_compressed), 32'h0);
        check_value("instr", instr, 32'h0);
        for (idx = 0; idx < vec_word.size(); idx++) begin
            expand_one(vec_word[idx], vec_legal[idx], vec_instr[idx], 1'b1);
        end
        // Low bits 11 mark a 32-bit word
        for (idx = 0; idx < random_words; idx++) begin
            rng_state = xorshift32(rng_state);
            expand_one(rng_state[15:0] | 16'h0003, 1'b0, 32'h0, 1'b0);
        end
        stream_vectors();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== build.f ====
verilog/rv_isa_pkg.sv
verilog/rvc_pkg.sv
verilog/rvc_quadrant0.sv
verilog/rvc_quadrant1.sv
verilog/rvc_quadrant2.sv
verilog/rvc_expander.sv
test/rvc_expander_asserts.sv
test/tb_rvc_expander.sv

// ==== Makefile ====
# Verilator build and run of the RVC expander testbench

TOP := tb_rvc_expander

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -f build.f \
		--top-module $(TOP) -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@if ! grep -q "Test completed successfully" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== test/rvc_testdata.txt ====
# Columns: cinstr, expected legal, expected 32-bit instruction (all hex, RV64C)
# Quadrant 0
0040 1 00410413
0000 0 00000000
5c7c 1 07c42783
7df0 1 0f85b603
dc7c 1 06f42e23
e504 1 00953423
2504 0 00000000
a504 0 00000000
# Quadrant 1
0001 1 00000013
157d 1 fff50513
2505 1 0015051b
2005 0 00000000
5581 1 fe000593
7101 1 e0010113
6101 0 00000000
75fd 1 fffff5b7
6005 0 00000000
90fd 1 03f4d493
840d 1 40345413
9941 1 ff057513
8c05 1 40940433
8c25 1 00944433
8d4d 1 00b56533
8ff9 1 00e7f7b3
9c05 1 4094043b
9c25 1 0094043b
9c45 0 00000000
bffd 1 fffff06f
a101 1 4000006f
fcfd 1 fe049fe3
c501 1 00050463
# Quadrant 2
050e 1 00351513
000e 0 00000000
4512 1 00412503
65a2 1 00813583
c22a 1 00a12223
e42e 1 00b13423
8082 1 00008067
8002 0 00000000
852e 1 00b00533
9002 1 00100073
9502 1 000500e7
952e 1 00b50533
2512 0 00000000
a22a 0 00000000
